// ==== sim.f ====
design/cpuPkg.sv
design/busMux.sv
design/registerFile.sv
design/aluUnit.sv
design/memoryPort.sv
design/controlSequencer.sv
design/cpuTop.sv
bench/cpuTop_chk.sv
bench/cpuTb.sv

// ==== bench/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    logic                         Clock;
    logic                         rst;
    logic [cpuPkg::dataWidth-1:0] memDataIn;
    logic [cpuPkg::dataWidth-1:0] memAddr;
    logic                         memRead;
    logic [cpuPkg::dataWidth-1:0] outData;
    logic                         outStrobe;
    logic                         halted;

    logic [cpuPkg::dataWidth-1:0] progMem [256];
    logic [cpuPkg::dataWidth-1:0] shadow [cpuPkg::regCount];    // Expected register contents.
    logic [cpuPkg::dataWidth-1:0] shadowHi;
    logic [cpuPkg::dataWidth-1:0] shadowLo;
    logic [cpuPkg::dataWidth-1:0] expected [$];
    logic [31:0]                  rngState;
    logic                         haltSeen;
    int                           progLen;
    int                           errorCount;
    int                           checkCount;

    cpuPkg::opcodeT aluOps [4] = '{cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr};
    cpuPkg::opcodeT shiftOps [5] = '{cpuPkg::opShr, cpuPkg::opShra, cpuPkg::opShl,
                                     cpuPkg::opRor, cpuPkg::opRol};

    cpuTop uut (
        .Clock(Clock), .rst(rst), .memDataIn(memDataIn), .memAddr(memAddr),
        .memRead(memRead), .outData(outData), .outStrobe(outStrobe), .halted(halted)
    );

    assign memDataIn = progMem[memAddr[7:0]];    // Combinational program memory.

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    // ********************
    // Reference model
    // ********************
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // One-operand ops work on a.
    function automatic logic [63:0] refCalc(cpuPkg::opcodeT op, logic [31:0] a, logic [31:0] b);
        logic [4:0]  n;
        logic [63:0] wideA;
        logic [63:0] wideB;
        logic [63:0] tmp;
        logic [31:0] r;
        n     = b[4:0];
        wideA = {{32{a[31]}}, a};
        wideB = {{32{b[31]}}, b};
        tmp   = wideA >> n;
        r     = '0;
        case (op)
            cpuPkg::opAdd:  r = a + b;
            cpuPkg::opSub:  r = a - b;
            cpuPkg::opAnd:  r = a & b;
            cpuPkg::opOr:   r = a | b;
            cpuPkg::opShr:  r = a >> n;
            cpuPkg::opShra: r = tmp[31:0];
            cpuPkg::opShl:  r = a << n;
            cpuPkg::opRor:  r = (n == 0) ? a : ((a >> n) | (a << (32 - n)));
            cpuPkg::opRol:  r = (n == 0) ? a : ((a << n) | (a >> (32 - n)));
            cpuPkg::opMul:  return wideA * wideB;
            cpuPkg::opNeg:  r = ~a + 1'b1;
            cpuPkg::opNot:  r = ~a;
            default:        r = '0;
        endcase
        return {32'b0, r};
    endfunction

    function automatic logic [31:0] encodeInstr(logic [4:0] op, logic [3:0] ra, logic [3:0] rb,
                                                logic [3:0] rc, logic [14:0] k);
        logic [31:0] w;
        w = '0;
        w[cpuPkg::opLsb +: cpuPkg::opWidth]       = op;
        w[cpuPkg::raLsb +: cpuPkg::regSelWidth]   = ra;
        w[cpuPkg::rbLsb +: cpuPkg::regSelWidth]   = rb;
        w[cpuPkg::rcLsb +: cpuPkg::regSelWidth]   = rc;
        w[cpuPkg::constLsb +: cpuPkg::constWidth] = k;
        return w;
    endfunction

    task automatic putWord(input logic [31:0] w);
        progMem[progLen] = w;
        progLen++;
    endtask

    task automatic loadConst(input logic [3:0] ra, input logic [14:0] k);
        putWord(encodeInstr(cpuPkg::opLdi, ra, 4'd0, 4'd0, k));
        if (ra != 0)
            shadow[ra] = {{(cpuPkg::dataWidth - cpuPkg::constWidth){k[14]}}, k};
    endtask

    task automatic runOp(input cpuPkg::opcodeT op, input logic [3:0] ra, input logic [3:0] rb,
                         input logic [3:0] rc);
        logic [63:0] res;
        putWord(encodeInstr(op, ra, rb, rc, 15'd0));
        res = refCalc(op, shadow[rb], shadow[rc]);
        if (op == cpuPkg::opMul) begin
            shadowHi = res[63:32];
            shadowLo = res[31:0];
        end else if (ra != 0) begin
            shadow[ra] = res[31:0];    // Register 0 keeps zero.
        end
    endtask

    task automatic moveFrom(input cpuPkg::opcodeT op, input logic [3:0] ra);
        putWord(encodeInstr(op, ra, 4'd0, 4'd0, 15'd0));
        if (ra != 0)
            shadow[ra] = (op == cpuPkg::opMfhi) ? shadowHi : shadowLo;
    endtask

    task automatic outReg(input logic [3:0] rb);
        putWord(encodeInstr(cpuPkg::opOut, 4'd0, rb, 4'd0, 15'd0));
        expected.push_back(shadow[rb]);
    endtask

    task automatic buildProgram();
        logic [31:0] rnd;
        logic [31:0] rnd2;
        progLen  = 0;
        shadowHi = '0;
        shadowLo = '0;
        for (int i = 0; i < 256; i++)
            progMem[i] = {cpuPkg::opHalt, 27'(i)};    // Unused words halt.
        for (int i = 0; i < cpuPkg::regCount; i++)
            shadow[i] = '0;
        loadConst(4'd1, 15'h1234);
        outReg(4'd1);
        loadConst(4'd2, 15'h4abc);    // Negative constant.
        outReg(4'd2);
        for (int n = 0; n < 4; n++) begin
            rnd  = nextRandom();
            rnd2 = nextRandom();
            loadConst(4'd1, rnd[14:0]);
            loadConst(4'd2, rnd2[14:0]);
            for (int k = 0; k < 4; k++) begin
                runOp(aluOps[k], 4'd3, 4'd1, 4'd2);
                outReg(4'd3);
            end
        end
        // ********************
        // Shifts on a wide value
        // ********************
        rnd  = nextRandom();
        rnd2 = nextRandom();
        loadConst(4'd4, rnd[14:0]);
        loadConst(4'd5, 15'd16);
        runOp(cpuPkg::opShl, 4'd4, 4'd4, 4'd5);
        loadConst(4'd6, rnd2[14:0]);
        runOp(cpuPkg::opOr, 4'd4, 4'd4, 4'd6);
        outReg(4'd4);
        for (int n = 0; n < 4; n++) begin
            rnd = nextRandom();
            case (n)
                0:       loadConst(4'd5, 15'd0);
                1:       loadConst(4'd5, 15'd31);
                default: loadConst(4'd5, rnd[14:0]);
            endcase
            for (int k = 0; k < 5; k++) begin
                runOp(shiftOps[k], 4'd7, 4'd4, 4'd5);
                outReg(4'd7);
            end
        end
        rnd = nextRandom();
        loadConst(4'd8, rnd[14:0]);
        runOp(cpuPkg::opMul, 4'd0, 4'd4, 4'd8);
        moveFrom(cpuPkg::opMfhi, 4'd9);
        moveFrom(cpuPkg::opMflo, 4'd10);
        outReg(4'd9);
        outReg(4'd10);
        runOp(cpuPkg::opNeg, 4'd11, 4'd4, 4'd0);
        runOp(cpuPkg::opNot, 4'd12, 4'd8, 4'd0);
        outReg(4'd11);
        outReg(4'd12);
        loadConst(4'd0, 15'h0155);
        outReg(4'd0);
        runOp(cpuPkg::opAdd, 4'd0, 4'd1, 4'd2);
        outReg(4'd0);
        putWord(encodeInstr(5'd20, 4'd3, 4'd4, 4'd8, 15'h7fff));    // Undefined codes.
        putWord(encodeInstr(5'd31, 4'd3, 4'd4, 4'd5, 15'h0001));
        outReg(4'd3);
        putWord(encodeInstr(cpuPkg::opHalt, 4'd0, 4'd0, 4'd0, 15'd0));
        putWord(encodeInstr(cpuPkg::opOut, 4'd0, 4'd1, 4'd0, 15'd0));    // Never reached.
    endtask

    // ********************
    // Checks
    // ********************
    task automatic checkData(input string name, input logic [cpuPkg::dataWidth-1:0] expVal,
                             input logic [cpuPkg::dataWidth-1:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errorCount++;
            $display("Fail %0t %s expected %h got %h", $time, name, expVal, actVal);
        end
    endtask

    task automatic checkHalt(input logic expVal, input logic actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errorCount++;
            $display("Fail %0t halted expected %b got %b", $time, expVal, actVal);
        end
    endtask

    always @(negedge Clock) begin
        if (!rst) begin
            if (outStrobe) begin
                if (haltSeen) begin
                    errorCount++;
                    $display("Output pulse at %0t after the processor halted", $time);
                end else if (expected.size() == 0) begin
                    errorCount++;
                    $display("Output pulse at %0t with no result pending", $time);
                end else begin
                    checkData("outData", expected.pop_front(), outData);
                end
            end
            if (haltSeen) begin
                checkHalt(1'b1, halted);
                if (memRead) begin
                    errorCount++;
                    $display("Memory read at %0t while halted", $time);
                end
            end
            if (halted)
                haltSeen = 1'b1;
        end
    end

    initial begin
        int cycles;
        rst        = 1'b1;
        haltSeen   = 1'b0;
        errorCount = 0;
        checkCount = 0;
        rngState   = 32'd50;
        buildProgram();
        repeat (2) @(posedge Clock);
        #2 rst = 1'b0;
        @(negedge Clock);
        checkHalt(1'b0, halted);
        cycles = 0;
        while (!halted && cycles < 4000) begin
            @(negedge Clock);
            cycles++;
        end
        if (!halted) begin
            errorCount++;
            $display("Timeout: halted did not rise within %0d cycles", cycles);
        end
        repeat (8) @(negedge Clock);    // Quiet period after halt.
        if (expected.size() != 0) begin
            errorCount++;
            $display("%0d expected output pulses never arrived", expected.size());
        end
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checkCount, errorCount,
                 uut.chk.failCount);
        if (errorCount == 0 && uut.chk.failCount == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/cpuTop_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTopChk (
    input wire Clock,
    input wire rst,
    input wire pcOut,
    input wire mdrOut,
    input wire zLowOut,
    input wire zHighOut,
    input wire hiOut,
    input wire loOut,
    input wire regOut,
    input wire constOut,
    input wire pcIn,
    input wire marIn,
    input wire mdrIn,
    input wire irIn,
    input wire yIn,
    input wire zIn,
    input wire hiIn,
    input wire loIn,
    input wire regIn,
    input wire incPc,
    input wire memRead,
    input wire outStrobe,
    input wire halted
);

    logic [7:0]  sources;
    logic [10:0] loads;
    int          failCount;

    initial failCount = 0;

    assign sources = {pcOut, mdrOut, zLowOut, zHighOut, hiOut, loOut, regOut, constOut};
    assign loads   = {pcIn, marIn, mdrIn, irIn, yIn, zIn, hiIn, loIn, regIn, incPc, memRead};

    // ********************
    // Bus and strobes
    // ********************
    singleSource: assert property (@(posedge Clock) disable iff (rst) $onehot0(sources))
        else begin
            $error("More than one bus source active.");
            failCount++;
        end

    quietAfterReset: assert property (@(posedge Clock)
        rst |=> (sources == '0) && (loads == '0) && !outStrobe && !halted)
        else begin
            $error("Strobes active in the cycle after reset.");
            failCount++;
        end

    outPulse: assert property (@(posedge Clock) disable iff (rst) outStrobe |=> !outStrobe)
        else begin
            $error("Output strobe held for two cycles.");
            failCount++;
        end

    haltSticky: assert property (@(posedge Clock) (halted && !rst) |=> halted)
        else begin
            $error("Halted dropped without reset.");
            failCount++;
        end

endmodule

bind cpuTop cpuTopChk chk (.*);

`default_nettype wire

// ==== design/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
    input  wire                          Clock,
    input  wire                          rst,
    input  wire [cpuPkg::dataWidth-1:0]  memDataIn,
    output logic [cpuPkg::dataWidth-1:0] memAddr,
    output logic                         memRead,
    output logic [cpuPkg::dataWidth-1:0] outData,
    output logic                         outStrobe,
    output logic                         halted
);

    logic [cpuPkg::dataWidth-1:0]   busData;
    logic [cpuPkg::dataWidth-1:0]   pcValue;
    logic [cpuPkg::dataWidth-1:0]   mdrValue;
    logic [cpuPkg::dataWidth-1:0]   zLow;
    logic [cpuPkg::dataWidth-1:0]   zHigh;
    logic [cpuPkg::dataWidth-1:0]   hiValue;
    logic [cpuPkg::dataWidth-1:0]   loValue;
    logic [cpuPkg::dataWidth-1:0]   regValue;
    logic [cpuPkg::dataWidth-1:0]   constValue;
    logic [cpuPkg::regSelWidth-1:0] regSel;
    cpuPkg::opcodeT                 aluOp;
    logic pcOut, mdrOut, zLowOut, zHighOut, hiOut, loOut, regOut, constOut;
    logic pcIn, marIn, mdrIn, irIn, yIn, zIn, hiIn, loIn, regIn, incPc;

    controlSequencer sequencer (
        .Clock(Clock), .rst(rst), .busData(busData),
        .pcOut(pcOut), .mdrOut(mdrOut), .zLowOut(zLowOut), .zHighOut(zHighOut),
        .hiOut(hiOut), .loOut(loOut), .regOut(regOut), .constOut(constOut),
        .pcIn(pcIn), .marIn(marIn), .mdrIn(mdrIn), .irIn(irIn), .yIn(yIn),
        .zIn(zIn), .hiIn(hiIn), .loIn(loIn), .regIn(regIn), .incPc(incPc),
        .memRead(memRead), .regSel(regSel), .aluOp(aluOp),
        .constValue(constValue), .outData(outData), .outStrobe(outStrobe),
        .halted(halted)
    );

    busMux bus (
        .pcValue(pcValue), .mdrValue(mdrValue), .zLow(zLow), .zHigh(zHigh),
        .hiValue(hiValue), .loValue(loValue), .regValue(regValue),
        .constValue(constValue), .pcOut(pcOut), .mdrOut(mdrOut),
        .zLowOut(zLowOut), .zHighOut(zHighOut), .hiOut(hiOut), .loOut(loOut),
        .regOut(regOut), .constOut(constOut), .busData(busData)
    );

    registerFile regFile (
        .Clock(Clock), .rst(rst), .regSel(regSel), .regIn(regIn),
        .busData(busData), .regValue(regValue)
    );

    aluUnit alu (
        .Clock(Clock), .rst(rst), .busData(busData), .yIn(yIn), .zIn(zIn),
        .hiIn(hiIn), .loIn(loIn), .aluOp(aluOp), .zLow(zLow), .zHigh(zHigh),
        .hiValue(hiValue), .loValue(loValue)
    );

    memoryPort memPort (
        .Clock(Clock), .rst(rst), .busData(busData), .memDataIn(memDataIn),
        .pcIn(pcIn), .incPc(incPc), .marIn(marIn), .mdrIn(mdrIn),
        .memRead(memRead), .pcValue(pcValue), .mdrValue(mdrValue),
        .memAddr(memAddr)
    );

endmodule

`default_nettype wire

// ==== design/controlSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
    input  wire                           Clock,
    input  wire                           rst,
    input  wire [cpuPkg::dataWidth-1:0]   busData,
    output logic                          pcOut,
    output logic                          mdrOut,
    output logic                          zLowOut,
    output logic                          zHighOut,
    output logic                          hiOut,
    output logic                          loOut,
    output logic                          regOut,
    output logic                          constOut,
    output logic                          pcIn,
    output logic                          marIn,
    output logic                          mdrIn,
    output logic                          irIn,
    output logic                          yIn,
    output logic                          zIn,
    output logic                          hiIn,
    output logic                          loIn,
    output logic                          regIn,
    output logic                          incPc,
    output logic                          memRead,
    output logic [cpuPkg::regSelWidth-1:0] regSel,
    output cpuPkg::opcodeT                aluOp,
    output logic [cpuPkg::dataWidth-1:0]  constValue,
    output logic [cpuPkg::dataWidth-1:0]  outData,
    output logic                          outStrobe,
    output logic                          halted
);

    cpuPkg::stateT                  state;
    cpuPkg::stateT                  nextState;
    cpuPkg::opcodeT                 opCode;
    logic [cpuPkg::dataWidth-1:0]   irReg;
    logic [cpuPkg::regSelWidth-1:0] ra;
    logic [cpuPkg::regSelWidth-1:0] rb;
    logic [cpuPkg::regSelWidth-1:0] rc;
    logic                           twoOperand;
    logic                           oneOperand;

    // ********************
    // Field decode
    // ********************
    assign opCode = cpuPkg::opcodeT'(irReg[cpuPkg::opLsb +: cpuPkg::opWidth]);
    assign ra     = irReg[cpuPkg::raLsb +: cpuPkg::regSelWidth];
    assign rb     = irReg[cpuPkg::rbLsb +: cpuPkg::regSelWidth];
    assign rc     = irReg[cpuPkg::rcLsb +: cpuPkg::regSelWidth];
    assign constValue = {
        {(cpuPkg::dataWidth - cpuPkg::constWidth){irReg[cpuPkg::constLsb + cpuPkg::constWidth - 1]}},
        irReg[cpuPkg::constLsb +: cpuPkg::constWidth]
    };
    assign aluOp   = opCode;
    assign outData = busData;     // Valid while outStrobe is high.
    assign halted  = (state == cpuPkg::sHalted);

    always_comb begin
        twoOperand = 1'b0;
        oneOperand = 1'b0;
        case (opCode)
            cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
            cpuPkg::opShr, cpuPkg::opShra, cpuPkg::opShl, cpuPkg::opRor,
            cpuPkg::opRol, cpuPkg::opMul:
                twoOperand = 1'b1;
            cpuPkg::opNeg, cpuPkg::opNot:
                oneOperand = 1'b1;
            default: ;
        endcase
    end

    // ********************
    // T-state machine
    // ********************
    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= cpuPkg::sIdle;
            irReg <= '0;
        end else begin
            state <= nextState;
            if (irIn)
                irReg <= busData;
        end
    end

    always_comb begin
        case (state)
            cpuPkg::sIdle: nextState = cpuPkg::sT0;
            cpuPkg::sT0:   nextState = cpuPkg::sT1;
            cpuPkg::sT1:   nextState = cpuPkg::sT2;
            cpuPkg::sT2:   nextState = cpuPkg::sT3;
            cpuPkg::sT3: begin
                if (opCode == cpuPkg::opHalt)
                    nextState = cpuPkg::sHalted;
                else if (twoOperand || oneOperand)
                    nextState = cpuPkg::sT4;
                else
                    nextState = cpuPkg::sT0;    // Short ops end here.
            end
            cpuPkg::sT4:   nextState = cpuPkg::sT5;
            cpuPkg::sT5:   nextState = cpuPkg::sT0;
            default:       nextState = cpuPkg::sHalted;
        endcase
    end

    // ********************
    // Strobes
    // ********************
    always_comb begin
        pcOut     = 1'b0;
        mdrOut    = 1'b0;
        zLowOut   = 1'b0;
        zHighOut  = 1'b0;
        hiOut     = 1'b0;
        loOut     = 1'b0;
        regOut    = 1'b0;
        constOut  = 1'b0;
        pcIn      = 1'b0;
        marIn     = 1'b0;
        mdrIn     = 1'b0;
        irIn      = 1'b0;
        yIn       = 1'b0;
        zIn       = 1'b0;
        hiIn      = 1'b0;
        loIn      = 1'b0;
        regIn     = 1'b0;
        incPc     = 1'b0;
        memRead   = 1'b0;
        outStrobe = 1'b0;
        regSel    = ra;
        case (state)
            cpuPkg::sT0: begin
                pcOut = 1'b1;
                marIn = 1'b1;
                incPc = 1'b1;
            end
            cpuPkg::sT1: begin
                memRead = 1'b1;
                mdrIn   = 1'b1;
            end
            cpuPkg::sT2: begin
                mdrOut = 1'b1;
                irIn   = 1'b1;
            end
            cpuPkg::sT3: begin
                case (opCode)
                    cpuPkg::opLdi: begin
                        constOut = 1'b1;
                        regIn    = 1'b1;
                    end
                    cpuPkg::opMfhi: begin
                        hiOut = 1'b1;
                        regIn = 1'b1;
                    end
                    cpuPkg::opMflo: begin
                        loOut = 1'b1;
                        regIn = 1'b1;
                    end
                    cpuPkg::opOut: begin
                        regSel    = rb;
                        regOut    = 1'b1;
                        outStrobe = 1'b1;
                    end
                    default: begin
                        if (twoOperand) begin
                            regSel = rb;    // First operand into Y.
                            regOut = 1'b1;
                            yIn    = 1'b1;
                        end
                    end
                endcase
            end
            cpuPkg::sT4: begin
                regSel = oneOperand ? rb : rc;
                regOut = 1'b1;
                zIn    = 1'b1;
            end
            cpuPkg::sT5: begin
                if (opCode == cpuPkg::opMul) begin
                    hiIn = 1'b1;
                    loIn = 1'b1;
                end else begin
                    zLowOut = 1'b1;
                    regIn   = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/memoryPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module memoryPort (
    input  wire                          Clock,
    input  wire                          rst,
    input  wire [cpuPkg::dataWidth-1:0]  busData,
    input  wire [cpuPkg::dataWidth-1:0]  memDataIn,
    input  wire                          pcIn,
    input  wire                          incPc,
    input  wire                          marIn,
    input  wire                          mdrIn,
    input  wire                          memRead,
    output logic [cpuPkg::dataWidth-1:0] pcValue,
    output logic [cpuPkg::dataWidth-1:0] mdrValue,
    output logic [cpuPkg::dataWidth-1:0] memAddr
);

    logic [cpuPkg::dataWidth-1:0] mdrNext;

    // Read data wins over the bus.
    assign mdrNext = memRead ? memDataIn : busData;

    always_ff @(posedge Clock) begin
        if (rst) begin
            pcValue  <= '0;
            memAddr  <= '0;
            mdrValue <= '0;
        end else begin
            if (pcIn)
                pcValue <= busData;
            else if (incPc)
                pcValue <= pcValue + 1'b1;    // Word addressed.
            if (marIn)
                memAddr <= busData;
            if (mdrIn)
                mdrValue <= mdrNext;
        end
    end

endmodule

`default_nettype wire

// ==== design/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  wire                          Clock,
    input  wire                          rst,
    input  wire [cpuPkg::dataWidth-1:0]  busData,
    input  wire                          yIn,
    input  wire                          zIn,
    input  wire                          hiIn,
    input  wire                          loIn,
    input  wire cpuPkg::opcodeT          aluOp,
    output logic [cpuPkg::dataWidth-1:0] zLow,
    output logic [cpuPkg::dataWidth-1:0] zHigh,
    output logic [cpuPkg::dataWidth-1:0] hiValue,
    output logic [cpuPkg::dataWidth-1:0] loValue
);

    logic [cpuPkg::dataWidth-1:0]          yReg;
    logic [2*cpuPkg::dataWidth-1:0]        zReg;
    logic [cpuPkg::dataWidth-1:0]          lowResult;
    logic [cpuPkg::dataWidth-1:0]          highResult;
    logic signed [2*cpuPkg::dataWidth-1:0] product;
    logic [2*cpuPkg::dataWidth-1:0]        doubled;
    logic [2*cpuPkg::dataWidth-1:0]        rorTmp;
    logic [2*cpuPkg::dataWidth-1:0]        rolTmp;
    logic [cpuPkg::shiftWidth-1:0]         shamt;

    // ********************
    // Operation logic
    // ********************
    assign shamt   = busData[cpuPkg::shiftWidth-1:0];
    assign doubled = {yReg, yReg};         // Rotates fall out of a double shift.
    assign rorTmp  = doubled >> shamt;
    assign rolTmp  = doubled << shamt;
    assign product = $signed(yReg) * $signed(busData);

    always_comb begin
        highResult = '0;
        lowResult  = '0;
        case (aluOp)
            cpuPkg::opAdd:  lowResult = yReg + busData;
            cpuPkg::opSub:  lowResult = yReg - busData;
            cpuPkg::opAnd:  lowResult = yReg & busData;
            cpuPkg::opOr:   lowResult = yReg | busData;
            cpuPkg::opShr:  lowResult = yReg >> shamt;
            cpuPkg::opShra: lowResult = $signed(yReg) >>> shamt;
            cpuPkg::opShl:  lowResult = yReg << shamt;
            cpuPkg::opRor:  lowResult = rorTmp[cpuPkg::dataWidth-1:0];
            cpuPkg::opRol:  lowResult = rolTmp[2*cpuPkg::dataWidth-1:cpuPkg::dataWidth];
            cpuPkg::opMul:  {highResult, lowResult} = product;
            cpuPkg::opNeg:  lowResult = -busData;    // Operand comes straight off the bus.
            cpuPkg::opNot:  lowResult = ~busData;
            default:        lowResult = '0;
        endcase
    end

    // ********************
    // Registers
    // ********************
    always_ff @(posedge Clock) begin
        if (rst) begin
            yReg    <= '0;
            zReg    <= '0;
            hiValue <= '0;
            loValue <= '0;
        end else begin
            if (yIn)
                yReg <= busData;
            if (zIn)
                zReg <= {highResult, lowResult};
            if (hiIn)
                hiValue <= zHigh;     // HI and LO load from Z, not the bus.
            if (loIn)
                loValue <= zLow;
        end
    end

    assign zLow  = zReg[cpuPkg::dataWidth-1:0];
    assign zHigh = zReg[2*cpuPkg::dataWidth-1:cpuPkg::dataWidth];

endmodule

`default_nettype wire

// ==== design/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  wire                           Clock,
    input  wire                           rst,
    input  wire [cpuPkg::regSelWidth-1:0] regSel,
    input  wire                           regIn,
    input  wire [cpuPkg::dataWidth-1:0]   busData,
    output logic [cpuPkg::dataWidth-1:0]  regValue
);

    logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];
    logic                         writeEn;

    // Register 0 never takes a write.
    assign writeEn = regIn && (regSel != '0);

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[regSel] <= busData;
        end
    end

    always_comb begin
        if (regSel == '0)
            regValue = '0;    // Hardwired zero.
        else
            regValue = regs[regSel];
    end

endmodule

`default_nettype wire

// ==== design/busMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module busMux (
    input  wire [cpuPkg::dataWidth-1:0] pcValue,
    input  wire [cpuPkg::dataWidth-1:0] mdrValue,
    input  wire [cpuPkg::dataWidth-1:0] zLow,
    input  wire [cpuPkg::dataWidth-1:0] zHigh,
    input  wire [cpuPkg::dataWidth-1:0] hiValue,
    input  wire [cpuPkg::dataWidth-1:0] loValue,
    input  wire [cpuPkg::dataWidth-1:0] regValue,
    input  wire [cpuPkg::dataWidth-1:0] constValue,
    input  wire                         pcOut,
    input  wire                         mdrOut,
    input  wire                         zLowOut,
    input  wire                         zHighOut,
    input  wire                         hiOut,
    input  wire                         loOut,
    input  wire                         regOut,
    input  wire                         constOut,
    output logic [cpuPkg::dataWidth-1:0] busData
);

    // One source at a time, so an AND-OR tree is enough.
    always_comb begin
        busData = '0;
        if (pcOut)
            busData = busData | pcValue;
        if (mdrOut)
            busData = busData | mdrValue;
        if (zLowOut)
            busData = busData | zLow;
        if (zHighOut)
            busData = busData | zHigh;
        if (hiOut)
            busData = busData | hiValue;
        if (loOut)
            busData = busData | loValue;
        if (regOut)
            busData = busData | regValue;
        if (constOut)
            busData = busData | constValue;    // Sign-extended immediate.
    end

endmodule

`default_nettype wire

// ==== design/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // ********************
    // Widths
    // ********************
    localparam int dataWidth   = 32;
    localparam int regCount    = 16;
    localparam int regSelWidth = 4;
    localparam int opWidth     = 5;
    localparam int constWidth  = 15;
    localparam int shiftWidth  = 5;    // Low bits of rc used as amount.

    // ********************
    // Instruction fields
    // ********************
    localparam int opLsb    = 27;
    localparam int raLsb    = 23;
    localparam int rbLsb    = 19;
    localparam int rcLsb    = 15;
    localparam int constLsb = 0;

    typedef enum logic [opWidth-1:0] {
        opLdi  = 5'd0,
        opAdd  = 5'd1,
        opSub  = 5'd2,
        opAnd  = 5'd3,
        opOr   = 5'd4,
        opShr  = 5'd5,
        opShra = 5'd6,
        opShl  = 5'd7,
        opRor  = 5'd8,
        opRol  = 5'd9,
        opMul  = 5'd10,
        opNeg  = 5'd11,
        opNot  = 5'd12,
        opMfhi = 5'd13,
        opMflo = 5'd14,
        opOut  = 5'd15,
        opHalt = 5'd16     // Codes above this are no-ops.
    } opcodeT;

    typedef enum logic [2:0] {
        sIdle, sT0, sT1, sT2, sT3, sT4, sT5, sHalted
    } stateT;

endpackage

`default_nettype wire
